//--- hw/rfnoc_loopback_pkg.sv
/* Shared CHDR types, settings addresses and the header/sample word union
   for the loopback block */
package rfnoc_loopback_pkg;

  localparam int CHDR_W = 64;

  // Settings addresses in the base 128 register region
  localparam logic [7:0] SR_NEXT_DST  = 8'd129;
  localparam logic [7:0] SR_CLEAR_SEQ = 8'd130;

  typedef enum logic [1:0] {
    PKT_DATA = 2'd0,
    PKT_FC   = 2'd1,
    PKT_CMD  = 2'd2,
    PKT_RESP = 2'd3
  } pkt_type_e;

  typedef struct packed {
    pkt_type_e   pkt_type;
    logic        has_time;
    logic        eob;
    logic [11:0] seqnum;
    logic [15:0] length;   // bytes, header included
    logic [15:0] src_sid;
    logic [15:0] dst_sid;
  } chdr_hdr_t;

  typedef struct packed {
    logic [31:0] sample_hi;
    logic [31:0] sample_lo;
  } sample_pair_t;

  // First beat of a packet is a header, later beats carry sample pairs
  typedef union packed {
    chdr_hdr_t    hdr;
    sample_pair_t smp;
  } chdr_word_u;

  typedef struct packed {
    logic        last;
    logic [31:0] data;
  } sample_t;

  // One entry per data packet, from ingress to egress
  typedef struct packed {
    logic [15:0] length;
    logic        eob;
    logic [15:0] src_sid;
    logic [15:0] dst_sid;
    logic        seq_clr;
  } hdr_info_t;

  typedef struct packed {
    logic        stb;
    logic [7:0]  addr;
    logic [31:0] data;
  } setting_t;

endpackage

//--- hw/settings_regs.sv
`timescale 1ns/1ps
/* Settings register bank: next destination SID and sticky sequence clear */
module settings_regs (
  input  logic                         i_ce_clk,
  input  logic                         i_rst_n,
  input  rfnoc_loopback_pkg::setting_t i_setting,
  input  logic                         i_consume,
  output logic [15:0]                  o_next_dst,
  output logic                         o_clr_pending
);
  import rfnoc_loopback_pkg::*;

  logic wr_next_dst;
  logic wr_clear_seq;

  assign wr_next_dst  = i_setting.stb && (i_setting.addr == SR_NEXT_DST);
  assign wr_clear_seq = i_setting.stb && (i_setting.addr == SR_CLEAR_SEQ);

  always_ff @(posedge i_ce_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_next_dst    <= 16'd0;
      o_clr_pending <= 1'b0;
    end else begin
      if (wr_next_dst) begin
        o_next_dst <= i_setting.data[15:0];
      end
      // A fresh clear request wins over a consume in the same cycle
      if (wr_clear_seq) begin
        o_clr_pending <= 1'b1;
      end else if (i_consume) begin
        o_clr_pending <= 1'b0;
      end
    end
  end

endmodule

//--- hw/axis_fifo.sv
`timescale 1ns/1ps
/* Synchronous valid/ready FIFO with wrap-bit pointers */
module axis_fifo #(
  parameter int WIDTH = 32,
  parameter int SIZE  = 4
) (
  input  logic             i_ce_clk,
  input  logic             i_rst_n,
  input  logic [WIDTH-1:0] i_tdata,
  input  logic             i_tvalid,
  output logic             o_tready,
  output logic [WIDTH-1:0] o_tdata,
  output logic             o_tvalid,
  input  logic             i_tready
);

  localparam int DEPTH = 2 ** SIZE;

  logic [WIDTH-1:0] mem [DEPTH];
  logic [SIZE:0]    wr_ptr;
  logic [SIZE:0]    rd_ptr;
  logic [SIZE:0]    occupancy;
  logic             full;
  logic             empty;
  logic             push;
  logic             pop;

  // Same index with opposite wrap bits means full
  assign full      = (wr_ptr[SIZE] != rd_ptr[SIZE]) &&
                     (wr_ptr[SIZE-1:0] == rd_ptr[SIZE-1:0]);
  assign empty     = (wr_ptr == rd_ptr);
  assign occupancy = wr_ptr - rd_ptr;

  assign o_tready = !full;
  assign o_tvalid = !empty;
  assign push     = i_tvalid && !full;
  assign pop      = !empty && i_tready;

  // Head entry comes straight out of the register array
  assign o_tdata = mem[rd_ptr[SIZE-1:0]];

  always_ff @(posedge i_ce_clk) begin
    if (push) begin
      mem[wr_ptr[SIZE-1:0]] <= i_tdata;
    end
  end

  always_ff @(posedge i_ce_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
    end
  end

  a_occupancy: assert property (@(posedge i_ce_clk) disable iff (!i_rst_n)
    occupancy <= (SIZE+1)'(DEPTH));

endmodule

//--- hw/chdr_ingress.sv
`timescale 1ns/1ps
/* CHDR input side: header decode, command register writes and the
   split of data payload beats into 32-bit samples */
module chdr_ingress (
  input  logic                                  i_ce_clk,
  input  logic                                  i_rst_n,
  input  logic [rfnoc_loopback_pkg::CHDR_W-1:0] i_tdata,
  input  logic                                  i_tlast,
  input  logic                                  i_tvalid,
  output logic                                  o_tready,
  input  logic [15:0]                           i_next_dst,
  input  logic                                  i_clr_pending,
  output logic                                  o_consume,
  output rfnoc_loopback_pkg::setting_t          o_setting,
  output rfnoc_loopback_pkg::sample_t           o_smp,
  output logic                                  o_smp_valid,
  input  logic                                  i_smp_ready,
  output rfnoc_loopback_pkg::hdr_info_t         o_hdr,
  output logic                                  o_hdr_valid,
  input  logic                                  i_hdr_ready
);
  import rfnoc_loopback_pkg::*;

  typedef enum logic [1:0] {ST_HDR, ST_DATA, ST_CMD, ST_DROP} state_e;

  state_e      state;
  chdr_word_u  word;
  logic        is_data;
  logic        in_xfer;
  logic        lo_pending;
  logic        lo_last;
  logic [31:0] lo_data;
  logic        cmd_first;
  logic        set_stb_q;
  logic [7:0]  set_addr_q;
  logic [31:0] set_data_q;

  assign word    = i_tdata;
  assign is_data = (word.hdr.pkt_type == PKT_DATA);

  //////////////////////////////////////////////////////////////////////
  // Input handshake
  //////////////////////////////////////////////////////////////////////
  // Headers wait one cycle after a register write so they see the new value
  always_comb begin
    o_tready = 1'b0;
    if (!lo_pending) begin
      case (state)
        ST_HDR:  o_tready = !set_stb_q && (!is_data || i_hdr_ready);
        ST_DATA: o_tready = i_smp_ready;
        default: o_tready = 1'b1;
      endcase
    end
  end

  assign in_xfer = i_tvalid && o_tready;

  // High sample goes out with the beat, low sample one cycle later
  assign o_smp_valid = lo_pending || ((state == ST_DATA) && i_tvalid);

  always_comb begin
    if (lo_pending) begin
      o_smp.last = lo_last;
      o_smp.data = lo_data;
    end else begin
      o_smp.last = 1'b0;
      o_smp.data = word.smp.sample_hi;
    end
  end

  assign o_hdr_valid = (state == ST_HDR) && !lo_pending && !set_stb_q && i_tvalid && is_data;
  assign o_consume   = o_hdr_valid && i_hdr_ready;

  always_comb begin
    o_hdr.length  = word.hdr.length;
    o_hdr.eob     = word.hdr.eob;
    o_hdr.src_sid = word.hdr.dst_sid;
    o_hdr.dst_sid = i_next_dst;
    o_hdr.seq_clr = i_clr_pending;
  end

  always_comb begin
    o_setting.stb  = set_stb_q;
    o_setting.addr = set_addr_q;
    o_setting.data = set_data_q;
  end

  //////////////////////////////////////////////////////////////////////
  // Packet FSM
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge i_ce_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state      <= ST_HDR;
      lo_pending <= 1'b0;
      cmd_first  <= 1'b0;
      set_stb_q  <= 1'b0;
    end else begin
      set_stb_q <= 1'b0;
      if (lo_pending && i_smp_ready) begin
        lo_pending <= 1'b0;
      end
      if (in_xfer) begin
        case (state)
          ST_HDR: begin
            cmd_first <= 1'b1;
            if (!i_tlast) begin
              case (word.hdr.pkt_type)
                PKT_DATA: state <= ST_DATA;
                PKT_CMD:  state <= ST_CMD;
                default:  state <= ST_DROP;
              endcase
            end
          end
          ST_DATA: begin
            lo_pending <= 1'b1;
            if (i_tlast) state <= ST_HDR;
          end
          ST_CMD: begin
            // Only the first payload beat writes a register
            cmd_first <= 1'b0;
            set_stb_q <= cmd_first;
            if (i_tlast) state <= ST_HDR;
          end
          default: begin
            if (i_tlast) state <= ST_HDR;
          end
        endcase
      end
    end
  end

  always_ff @(posedge i_ce_clk) begin
    if (in_xfer && (state == ST_DATA)) begin
      lo_data <= word.smp.sample_lo;
      lo_last <= i_tlast;
    end
    if (in_xfer && (state == ST_CMD) && cmd_first) begin
      set_addr_q <= word.smp.sample_hi[7:0];
      set_data_q <= word.smp.sample_lo;
    end
  end

  // A refused sample is offered again unchanged
  a_smp_hold: assert property (@(posedge i_ce_clk) disable iff (!i_rst_n)
    o_smp_valid && !i_smp_ready |=> o_smp_valid && $stable(o_smp));

endmodule

//--- hw/chdr_egress.sv
`timescale 1ns/1ps
/* CHDR output side: sequence counter, header rebuild and packing of
   sample pairs into 64-bit beats */
module chdr_egress (
  input  logic                                  i_ce_clk,
  input  logic                                  i_rst_n,
  input  rfnoc_loopback_pkg::hdr_info_t         i_hdr,
  input  logic                                  i_hdr_valid,
  output logic                                  o_hdr_ready,
  input  rfnoc_loopback_pkg::sample_t           i_smp,
  input  logic                                  i_smp_valid,
  output logic                                  o_smp_ready,
  output logic [rfnoc_loopback_pkg::CHDR_W-1:0] o_tdata,
  output logic                                  o_tlast,
  output logic                                  o_tvalid,
  input  logic                                  i_tready
);
  import rfnoc_loopback_pkg::*;

  typedef enum logic [1:0] {PH_HDR, PH_HI, PH_LO} phase_e;

  phase_e      phase;
  logic [11:0] seq_cnt;
  logic [11:0] seq_now;
  logic [31:0] hi_q;
  logic        out_free;
  logic        hdr_load;
  logic        lo_load;
  logic        hdr_only;
  chdr_word_u  next_word;
  chdr_word_u  out_q;
  logic        out_last_q;
  logic        out_valid_q;

  // Output slot can take a new beat when empty or draining
  assign out_free    = !out_valid_q || i_tready;
  assign o_hdr_ready = (phase == PH_HDR) && out_free;
  assign hdr_load    = o_hdr_ready && i_hdr_valid;
  assign o_smp_ready = (phase == PH_HI) || ((phase == PH_LO) && out_free);
  assign lo_load     = (phase == PH_LO) && out_free && i_smp_valid;

  assign seq_now  = i_hdr.seq_clr ? 12'd0 : seq_cnt;
  assign hdr_only = (i_hdr.length <= 16'd8);

  always_comb begin
    next_word = '0;
    if (phase == PH_HDR) begin
      next_word.hdr = '{pkt_type: PKT_DATA, has_time: 1'b0, eob: i_hdr.eob,
                        seqnum: seq_now, length: i_hdr.length,
                        src_sid: i_hdr.src_sid, dst_sid: i_hdr.dst_sid};
    end else begin
      next_word.smp.sample_hi = hi_q;
      next_word.smp.sample_lo = i_smp.data;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Phase control and sequence counter
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge i_ce_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      phase       <= PH_HDR;
      seq_cnt     <= 12'd0;
      out_valid_q <= 1'b0;
    end else begin
      if (hdr_load) begin
        seq_cnt <= seq_now + 12'd1;
        phase   <= hdr_only ? PH_HDR : PH_HI;
      end else if ((phase == PH_HI) && i_smp_valid) begin
        phase <= PH_LO;
      end else if (lo_load) begin
        phase <= i_smp.last ? PH_HDR : PH_HI;
      end

      if (hdr_load || lo_load) begin
        out_valid_q <= 1'b1;
      end else if (i_tready) begin
        out_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge i_ce_clk) begin
    if ((phase == PH_HI) && i_smp_valid) begin
      hi_q <= i_smp.data;
    end
    if (hdr_load || lo_load) begin
      out_q      <= next_word;
      out_last_q <= hdr_load ? hdr_only : i_smp.last;
    end
  end

  assign o_tdata  = out_q;
  assign o_tlast  = out_last_q;
  assign o_tvalid = out_valid_q;

  a_out_hold: assert property (@(posedge i_ce_clk) disable iff (!i_rst_n)
    o_tvalid && !i_tready |=> o_tvalid && $stable(o_tdata) && $stable(o_tlast));

endmodule

//--- hw/noc_block_fifo_loopback.sv
`timescale 1ns/1ps
/* Loopback block top level: ingress, settings, sample and header FIFOs,
   egress */
module noc_block_fifo_loopback #(
  parameter int SAMPLE_FIFO_SIZE = 5,
  parameter int HDR_FIFO_SIZE    = 3
) (
  input  logic                                  i_ce_clk,
  input  logic                                  i_rst_n,
  input  logic [rfnoc_loopback_pkg::CHDR_W-1:0] i_tdata,
  input  logic                                  i_tlast,
  input  logic                                  i_tvalid,
  output logic                                  o_tready,
  output logic [rfnoc_loopback_pkg::CHDR_W-1:0] o_tdata,
  output logic                                  o_tlast,
  output logic                                  o_tvalid,
  input  logic                                  i_tready
);
  import rfnoc_loopback_pkg::*;

  setting_t    setting;
  logic [15:0] next_dst;
  logic        clr_pending;
  logic        consume;

  sample_t     smp_in;
  logic        smp_in_valid;
  logic        smp_in_ready;
  sample_t     smp_out;
  logic        smp_out_valid;
  logic        smp_out_ready;

  hdr_info_t   hdr_in;
  logic        hdr_in_valid;
  logic        hdr_in_ready;
  hdr_info_t   hdr_out;
  logic        hdr_out_valid;
  logic        hdr_out_ready;

  chdr_ingress ingress_i (
    .i_ce_clk(i_ce_clk), .i_rst_n(i_rst_n),
    .i_tdata(i_tdata), .i_tlast(i_tlast), .i_tvalid(i_tvalid), .o_tready(o_tready),
    .i_next_dst(next_dst), .i_clr_pending(clr_pending), .o_consume(consume),
    .o_setting(setting),
    .o_smp(smp_in), .o_smp_valid(smp_in_valid), .i_smp_ready(smp_in_ready),
    .o_hdr(hdr_in), .o_hdr_valid(hdr_in_valid), .i_hdr_ready(hdr_in_ready));

  settings_regs settings_i (
    .i_ce_clk(i_ce_clk), .i_rst_n(i_rst_n),
    .i_setting(setting), .i_consume(consume),
    .o_next_dst(next_dst), .o_clr_pending(clr_pending));

  ////////////////////////////////////////////////////////////////////
  // Sample and header-info queues
  ////////////////////////////////////////////////////////////////////
  axis_fifo #(.WIDTH($bits(sample_t)), .SIZE(SAMPLE_FIFO_SIZE)) smp_fifo_i (
    .i_ce_clk(i_ce_clk), .i_rst_n(i_rst_n),
    .i_tdata(smp_in), .i_tvalid(smp_in_valid), .o_tready(smp_in_ready),
    .o_tdata(smp_out), .o_tvalid(smp_out_valid), .i_tready(smp_out_ready));

  axis_fifo #(.WIDTH($bits(hdr_info_t)), .SIZE(HDR_FIFO_SIZE)) hdr_fifo_i (
    .i_ce_clk(i_ce_clk), .i_rst_n(i_rst_n),
    .i_tdata(hdr_in), .i_tvalid(hdr_in_valid), .o_tready(hdr_in_ready),
    .o_tdata(hdr_out), .o_tvalid(hdr_out_valid), .i_tready(hdr_out_ready));

  chdr_egress egress_i (
    .i_ce_clk(i_ce_clk), .i_rst_n(i_rst_n),
    .i_hdr(hdr_out), .i_hdr_valid(hdr_out_valid), .o_hdr_ready(hdr_out_ready),
    .i_smp(smp_out), .i_smp_valid(smp_out_valid), .o_smp_ready(smp_out_ready),
    .o_tdata(o_tdata), .o_tlast(o_tlast), .o_tvalid(o_tvalid), .i_tready(i_tready));

endmodule

//--- sim/tb_noc_block_fifo_loopback.sv
`timescale 1ns/1ps
/* Loopback block testbench: random CHDR packets, reference model of
   settings and sequence numbers, output beat checks and a cycle timeout */
module tb_noc_block_fifo_loopback;
  import rfnoc_loopback_pkg::*;

  localparam int NUM_PKTS       = 60;
  localparam int MAX_BEATS      = 16;
  // Enough single-beat data packets to carry the sequence number past 4095
  localparam int WRAP_PKTS      = 4100;
  // Two cycles per beat and a factor of four for back-pressure
  localparam int TIMEOUT_CYCLES = NUM_PKTS * (MAX_BEATS + 1) * 2 * 4 +
                                  WRAP_PKTS * 2 * 2 * 4 + 1000;

  logic              i_ce_clk = 1'b0;
  logic              i_rst_n;
  logic [CHDR_W-1:0] i_tdata;
  logic              i_tlast;
  logic              i_tvalid;
  logic              o_tready;
  logic [CHDR_W-1:0] o_tdata;
  logic              o_tlast;
  logic              o_tvalid;
  logic              i_tready;

  logic [31:0]       lcg_state      = 32'hdab8;
  // Model of the settings registers and the output sequence counter
  logic [15:0]       next_dst_model = 16'd0;
  logic              clr_model      = 1'b0;
  logic [11:0]       seq_model      = 12'd0;
  logic [CHDR_W-1:0] exp_data [$];
  logic              exp_last [$];
  string             exp_name [$];
  int                cycles         = 0;
  int                cycles_after_rst = 0;

  noc_block_fifo_loopback #(.SAMPLE_FIFO_SIZE(5), .HDR_FIFO_SIZE(3)) dut_i (
    .i_ce_clk(i_ce_clk), .i_rst_n(i_rst_n),
    .i_tdata(i_tdata), .i_tlast(i_tlast), .i_tvalid(i_tvalid), .o_tready(o_tready),
    .o_tdata(o_tdata), .o_tlast(o_tlast), .o_tvalid(o_tvalid), .i_tready(i_tready));

  always #4 i_ce_clk = ~i_ce_clk;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Next sequence number in the 12-bit field
  function automatic logic [11:0] seq_after(input logic [11:0] s);
    return s + 12'd1;
  endfunction

  task automatic fail_run(input string why);
    $display("TESTS FAILED");
    $fatal(1, "%s", why);
  endtask

  // Steps to the next falling edge and draws about 70 % ready
  task automatic next_cycle();
    @(negedge i_ce_clk);
    i_tready = ((lcg_next() >> 8) % 100) < 70;
  endtask

  task automatic send_beat(input logic [CHDR_W-1:0] data, input logic last);
    logic accepted;
    if (((lcg_next() >> 8) % 10) == 0) begin
      next_cycle();
    end
    i_tdata  = data;
    i_tlast  = last;
    i_tvalid = 1'b1;
    do begin
      @(posedge i_ce_clk);
      accepted = o_tready;
      next_cycle();
    end while (!accepted);
    i_tvalid = 1'b0;
  endtask

  task automatic expect_beat(input logic [CHDR_W-1:0] data, input logic last,
                             input string name);
    exp_data.push_back(data);
    exp_last.push_back(last);
    exp_name.push_back(name);
  endtask

  ////////////////////////////////////////////////////////////////////////
  // Packet senders
  ////////////////////////////////////////////////////////////////////////
  task automatic send_data_packet(input int idx, input int beats);
    chdr_word_u  in_word;
    chdr_word_u  out_word;
    logic [31:0] r;
    logic [11:0] seqnum;
    in_word = '0;
    r = lcg_next();
    in_word.hdr.pkt_type = PKT_DATA;
    in_word.hdr.has_time = r[30];
    in_word.hdr.eob      = r[31];
    in_word.hdr.seqnum   = r[27:16];
    in_word.hdr.length   = 16'((beats + 1) * 8);
    r = lcg_next();
    in_word.hdr.src_sid  = r[31:16];
    in_word.hdr.dst_sid  = r[15:0];
    // Registers as they stand when this header is accepted
    seqnum    = clr_model ? 12'd0 : seq_model;
    seq_model = seq_after(seqnum);
    clr_model = 1'b0;
    out_word  = '0;
    out_word.hdr.pkt_type = PKT_DATA;
    out_word.hdr.eob      = in_word.hdr.eob;
    out_word.hdr.seqnum   = seqnum;
    out_word.hdr.length   = in_word.hdr.length;
    out_word.hdr.src_sid  = in_word.hdr.dst_sid;
    out_word.hdr.dst_sid  = next_dst_model;
    expect_beat(out_word, 1'b0, $sformatf("data packet %0d header", idx));
    send_beat(in_word, 1'b0);
    for (int b = 0; b < beats; b++) begin
      in_word.smp.sample_hi = lcg_next();
      in_word.smp.sample_lo = lcg_next();
      expect_beat(in_word, b == beats - 1, $sformatf("data packet %0d beat %0d", idx, b));
      send_beat(in_word, b == beats - 1);
    end
  endtask

  // Command, flow control and response packets produce no output
  task automatic send_control_packet(input int idx, input pkt_type_e ptype, input int beats);
    chdr_word_u  word;
    logic [31:0] r;
    logic [7:0]  addr;
    word = '0;
    r = lcg_next();
    word.hdr.pkt_type = ptype;
    word.hdr.seqnum   = r[27:16];
    word.hdr.length   = 16'((beats + 1) * 8);
    word.hdr.src_sid  = r[15:0];
    send_beat(word, 1'b0);
    for (int b = 0; b < beats; b++) begin
      word.smp.sample_hi = lcg_next();
      word.smp.sample_lo = lcg_next();
      if ((ptype == PKT_CMD) && (b == 0)) begin
        case ((lcg_next() >> 8) % 3)
          0:       addr = SR_NEXT_DST;
          1:       addr = SR_CLEAR_SEQ;
          default: addr = {1'b0, word.smp.sample_hi[6:0]};
        endcase
        word.smp.sample_hi[7:0] = addr;
        if (addr == SR_NEXT_DST) begin
          next_dst_model = word.smp.sample_lo[15:0];
        end
        if (addr == SR_CLEAR_SEQ) begin
          clr_model = 1'b1;
        end
      end
      send_beat(word, b == beats - 1);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////
  // Output monitor and timeout
  ////////////////////////////////////////////////////////////////////////
  always @(posedge i_ce_clk) begin : monitor
    logic [CHDR_W-1:0] e_data;
    logic              e_last;
    string             e_name;
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      fail_run($sformatf("Timeout after %0d cycles with %0d output beats still expected",
                         cycles, exp_data.size()));
    end else if (!i_rst_n) begin
      cycles_after_rst = 0;
      // Reset values are in place from the first clock edge on
      if (cycles > 1) begin
        assert (!o_tvalid) else fail_run("o_tvalid was high during reset");
        assert (o_tready) else fail_run("o_tready was low during reset");
      end
    end else if (cycles_after_rst < 2) begin
      cycles_after_rst = cycles_after_rst + 1;
      assert (!o_tvalid) else fail_run("o_tvalid was high in the first cycle after reset");
    end else if (o_tvalid && i_tready) begin
      assert (exp_data.size() != 0) begin
        e_data = exp_data.pop_front();
        e_last = exp_last.pop_front();
        e_name = exp_name.pop_front();
        assert ((o_tdata == e_data) && (o_tlast == e_last)) else begin
          $display("** Error %s: expected %h last %0b, actual %h last %0b",
                   e_name, e_data, e_last, o_tdata, o_tlast);
          fail_run("Output beat differs from the model");
        end
      end else begin
        fail_run("Output beat arrived while no data packet was pending");
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////
  initial begin
    int          beats;
    int          sel;
    logic [31:0] r;
    i_rst_n  = 1'b0;
    i_tdata  = '0;
    i_tlast  = 1'b0;
    i_tvalid = 1'b0;
    i_tready = 1'b0;
    repeat (10) next_cycle();
    i_rst_n = 1'b1;

    // Half data packets and the rest split over commands, flow control and responses
    for (int p = 0; p < NUM_PKTS; p++) begin
      r     = lcg_next();
      beats = 1 + int'((r >> 8) % MAX_BEATS);
      sel   = int'((r >> 20) % 20);
      if (sel < 10) begin
        send_data_packet(p, beats);
      end else if (sel < 14) begin
        send_control_packet(p, PKT_CMD, beats);
      end else if (sel < 17) begin
        send_control_packet(p, PKT_FC, beats);
      end else begin
        send_control_packet(p, PKT_RESP, beats);
      end
    end

    // Sequence number runs through 4095 and back to 0
    for (int p = 0; p < WRAP_PKTS; p++) begin
      send_data_packet(NUM_PKTS + p, 1);
    end

    while (exp_data.size() != 0) begin
      next_cycle();
    end
    // Quiet period in which a stray beat would reach the monitor
    repeat (100) next_cycle();
    if (exp_data.size() == 0) begin
      $display("TESTS PASSED");
      $finish;
    end else begin
      fail_run("Output beats still pending at the end of the run");
    end
  end

endmodule

//--- noc_block_fifo_loopback.f
hw/rfnoc_loopback_pkg.sv
hw/settings_regs.sv
hw/axis_fifo.sv
hw/chdr_ingress.sv
hw/chdr_egress.sv
hw/noc_block_fifo_loopback.sv
sim/tb_noc_block_fifo_loopback.sv

//--- Bender.yml
package:
  name: noc_block_fifo_loopback

sources:
  - hw/rfnoc_loopback_pkg.sv
  - hw/settings_regs.sv
  - hw/axis_fifo.sv
  - hw/chdr_ingress.sv
  - hw/chdr_egress.sv
  - hw/noc_block_fifo_loopback.sv
  - target: simulation
    files:
      - sim/tb_noc_block_fifo_loopback.sv
